//--- rtl/disp_pkg.sv
`default_nettype none

package disp_pkg;

    // what the dot matrix is asked to show
    typedef enum logic [1:0] {
        MODE_BLANK,
        MODE_GREET,
        MODE_COUNTDOWN,
        MODE_VICTORY
    } matrix_mode_t;

    // segments {dp, g, f, e, d, c, b, a}, active high
    typedef logic [7:0] seg_pattern_t;

    // cycles a digit or a matrix row stays selected
    localparam int SCAN_CYCLES = 4;
    localparam int SCAN_W = $clog2(SCAN_CYCLES);

    localparam seg_pattern_t DIGIT_SEGS [10] = '{
        8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66,
        8'h6d, 8'h7d, 8'h07, 8'h7f, 8'h6f
    };

    // smiley face, row 0 at the top
    localparam logic [7:0] GREET_PATTERN [8] = '{
        8'b0011_1100,
        8'b0100_0010,
        8'b1010_0101,
        8'b1000_0001,
        8'b1010_0101,
        8'b1001_1001,
        8'b0100_0010,
        8'b0011_1100
    };

endpackage

`default_nettype wire

//--- rtl/game_pkg.sv
`default_nettype none

package game_pkg;

    import disp_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_GREET,
        ST_MEMORIZE,
        ST_GUESS,
        ST_JUDGE,
        ST_VICTORY
    } game_state_t;

    typedef logic [1:0] level_t;
    typedef logic [6:0] target_t;

    localparam level_t FIRST_LEVEL = 2'd1;
    localparam level_t LAST_LEVEL = 2'd3;

    // bits of the target in play per level, entry 0 unused
    localparam int LEVEL_WIDTH [4] = '{7, 5, 6, 7};

    // any nonzero start value works for the lfsr
    localparam target_t LFSR_SEED = 7'h5a;

    // countdown, one matrix column per step
    localparam int COUNT_STEPS = 8;
    localparam int COUNT_STEP_CYCLES = 16;
    localparam int STEP_W = $clog2(COUNT_STEPS + 1);
    localparam int PRESC_W = $clog2(COUNT_STEP_CYCLES);

    // success beep
    localparam int BEEP_CYCLES = 64;
    localparam int TONE_HALF_CYCLES = 4;
    localparam int BEEP_W = $clog2(BEEP_CYCLES + 1);
    localparam int TONE_W = $clog2(TONE_HALF_CYCLES);

    // strobes and levels from the controller to the peripherals
    typedef struct packed {
        logic         count_start;
        matrix_mode_t matrix_mode;
        level_t       level;
        logic         beep_start;
        logic         capture;
    } game_ctrl_t;

endpackage

`default_nettype wire

//--- rtl/lfsr_random.sv
`timescale 1ns/100ps
`default_nettype none

module lfsr_random
    import game_pkg::*;
(
    input  wire     clk,
    input  wire     sw,
    input  wire     capture,
    output target_t target
);

    target_t lfsr;

    // x^7 + x^6 + 1, period 127
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            lfsr <= LFSR_SEED;
        else
            lfsr <= {lfsr[5:0], lfsr[6] ^ lfsr[5]};
    end

    // target holds until the next capture
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            target <= '0;
        else if (capture)
            target <= lfsr;
    end

endmodule

`default_nettype wire

//--- rtl/countdown_matrix.sv
`timescale 1ns/100ps
`default_nettype none

module countdown_matrix
    import game_pkg::*;
    import disp_pkg::*;
(
    input  wire          clk,
    input  wire          sw,
    input  wire          count_start,
    input  matrix_mode_t mode,
    output logic         count_over,
    output logic [7:0]   row,
    output logic [7:0]   colg,
    output logic [7:0]   colr
);

    logic [STEP_W-1:0]  steps_left;
    logic [PRESC_W-1:0] step_presc;
    logic [SCAN_W-1:0]  scan_presc;
    logic [2:0]         row_idx;
    logic [7:0]         bar;
    logic [7:0]         row_n;
    logic [7:0]         colg_n;
    logic [7:0]         colr_n;

    // countdown, one step every COUNT_STEP_CYCLES
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            steps_left <= '0;
            step_presc <= '0;
        end
        else if (count_start)
        begin
            steps_left <= STEP_W'(COUNT_STEPS);
            step_presc <= '0;
        end
        else if (steps_left != '0)
        begin
            if (step_presc == PRESC_W'(COUNT_STEP_CYCLES - 1))
            begin
                step_presc <= '0;
                steps_left <= steps_left - 1'b1;
            end
            else
                step_presc <= step_presc + 1'b1;
        end
    end

    assign count_over = (steps_left == '0);

    // row scan
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            scan_presc <= '0;
            row_idx <= '0;
        end
        else if (scan_presc == SCAN_W'(SCAN_CYCLES - 1))
        begin
            scan_presc <= '0;
            row_idx <= row_idx + 1'b1;
        end
        else
            scan_presc <= scan_presc + 1'b1;
    end

    // thermometer of the steps still to run
    assign bar = 8'((16'd1 << steps_left) - 16'd1);

    always_comb
    begin
        row_n = 8'd1 << row_idx;
        colg_n = '0;
        colr_n = '0;
        case (mode)
            MODE_GREET:
                colg_n = GREET_PATTERN[row_idx];
            MODE_COUNTDOWN:
                colg_n = bar;
            MODE_VICTORY:
                colr_n = '1;
            default:
                row_n = '0;
        endcase
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            row <= '0;
            colg <= '0;
            colr <= '0;
        end
        else
        begin
            row <= row_n;
            colg <= colg_n;
            colr <= colr_n;
        end
    end

endmodule

`default_nettype wire

//--- rtl/beeper.sv
`timescale 1ns/100ps
`default_nettype none

module beeper
    import game_pkg::*;
(
    input  wire  clk,
    input  wire  sw,
    input  wire  beep_start,
    output logic beep
);

    logic [BEEP_W-1:0] duration;
    logic [TONE_W-1:0] tone_cnt;

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            duration <= '0;
            tone_cnt <= '0;
            beep <= 1'b0;
        end
        else if (beep_start)
        begin
            duration <= BEEP_W'(BEEP_CYCLES);
            tone_cnt <= '0;
            beep <= 1'b0;
        end
        else if (duration != '0)
        begin
            duration <= duration - 1'b1;
            // square wave while the beep lasts
            if (tone_cnt == TONE_W'(TONE_HALF_CYCLES - 1))
            begin
                tone_cnt <= '0;
                beep <= ~beep;
            end
            else
                tone_cnt <= tone_cnt + 1'b1;
        end
        else
        begin
            tone_cnt <= '0;
            beep <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/level_display.sv
`timescale 1ns/100ps
`default_nettype none

module level_display
    import game_pkg::*;
    import disp_pkg::*;
(
    input  wire          clk,
    input  wire          sw,
    input  matrix_mode_t mode,
    input  level_t       level,
    output logic [7:0]   seg,
    output logic [7:0]   dig
);

    logic [SCAN_W-1:0] scan_presc;
    logic [2:0]        dig_idx;
    seg_pattern_t      level_seg;
    seg_pattern_t      seg_n;
    logic [7:0]        dig_n;

    // digit scan
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            scan_presc <= '0;
            dig_idx <= '0;
        end
        else if (scan_presc == SCAN_W'(SCAN_CYCLES - 1))
        begin
            scan_presc <= '0;
            dig_idx <= dig_idx + 1'b1;
        end
        else
            scan_presc <= scan_presc + 1'b1;
    end

    // victory always shows the final level
    assign level_seg = (mode == MODE_VICTORY) ? DIGIT_SEGS[LAST_LEVEL] : DIGIT_SEGS[level];

    always_comb
    begin
        seg_n = '0;
        dig_n = '1;
        if (mode == MODE_COUNTDOWN || mode == MODE_VICTORY)
        begin
            dig_n = ~(8'd1 << dig_idx);
            // only digit 0 carries the level
            if (dig_idx == 3'd0)
                seg_n = level_seg;
        end
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            seg <= '0;
            dig <= '1;
        end
        else
        begin
            seg <= seg_n;
            dig <= dig_n;
        end
    end

endmodule

`default_nettype wire

//--- rtl/game_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module game_fsm
    import game_pkg::*;
    import disp_pkg::*;
(
    input  wire         clk,
    input  wire         sw,
    input  wire         power,
    input  wire         launch,
    input  wire         confirm,
    input  target_t     guess,
    input  target_t     target,
    input  wire         count_over,
    output game_ctrl_t  ctrl,
    output logic [15:0] led
);

    game_state_t  state;
    game_state_t  state_n;
    level_t       level_n;
    matrix_mode_t mode_n;
    logic         restart;
    logic         count_start_n;
    logic         beep_start_n;
    logic         hit;
    target_t      cur_mask;
    logic [15:0]  led_n;

    function automatic target_t level_mask(level_t lvl);
        return target_t'((32'd1 << LEVEL_WIDTH[lvl]) - 32'd1);
    endfunction

    assign cur_mask = level_mask(ctrl.level);
    assign hit = ((guess ^ target) & cur_mask) == '0;

    always_comb
    begin
        state_n = state;
        level_n = ctrl.level;
        restart = 1'b0;
        count_start_n = 1'b0;
        beep_start_n = 1'b0;
        if (!power)
            state_n = ST_IDLE;
        else
        begin
            case (state)
                ST_IDLE:
                    state_n = ST_GREET;
                ST_GREET:
                    restart = launch;
                ST_MEMORIZE:
                begin
                    // ignore count_over in the cycle the countdown is started
                    if (launch)
                        restart = 1'b1;
                    else if (count_over && !ctrl.count_start)
                        state_n = ST_GUESS;
                end
                ST_GUESS:
                begin
                    if (launch)
                        restart = 1'b1;
                    else if (confirm)
                        state_n = ST_JUDGE;
                end
                ST_JUDGE:
                begin
                    beep_start_n = hit;
                    if (hit && ctrl.level == LAST_LEVEL)
                        state_n = ST_VICTORY;
                    else
                    begin
                        // wrong guess replays the same level and target
                        if (hit)
                            level_n = ctrl.level + 1'b1;
                        state_n = ST_MEMORIZE;
                        count_start_n = 1'b1;
                    end
                end
                ST_VICTORY:
                    restart = launch;
                default:
                    state_n = ST_IDLE;
            endcase
        end
        if (restart)
        begin
            state_n = ST_MEMORIZE;
            level_n = FIRST_LEVEL;
            count_start_n = 1'b1;
        end
    end

    always_comb
    begin
        case (state_n)
            ST_GREET:
                mode_n = MODE_GREET;
            ST_MEMORIZE, ST_GUESS, ST_JUDGE:
                mode_n = MODE_COUNTDOWN;
            ST_VICTORY:
                mode_n = MODE_VICTORY;
            default:
                mode_n = MODE_BLANK;
        endcase
    end

    // target visible only while memorizing
    assign led_n = (state_n == ST_MEMORIZE) ? {9'd0, target & level_mask(level_n)} : 16'd0;

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            state <= ST_IDLE;
            led <= '0;
            ctrl <= '{
                count_start: 1'b0,
                matrix_mode: MODE_BLANK,
                level:       FIRST_LEVEL,
                beep_start:  1'b0,
                capture:     1'b0
            };
        end
        else
        begin
            state <= state_n;
            led <= led_n;
            ctrl.count_start <= count_start_n;
            ctrl.matrix_mode <= mode_n;
            ctrl.level <= level_n;
            ctrl.beep_start <= beep_start_n;
            ctrl.capture <= restart;
        end
    end

endmodule

`default_nettype wire

//--- rtl/memory_game_top.sv
`timescale 1ns/100ps
`default_nettype none

module memory_game_top
    import game_pkg::*;
(
    input  wire         clk,
    input  wire         sw,
    input  wire         power,
    input  wire         launch,
    input  wire         confirm,
    input  target_t     guess,
    output logic [15:0] led,
    output logic [7:0]  seg,
    output logic [7:0]  dig,
    output logic [7:0]  row,
    output logic [7:0]  colg,
    output logic [7:0]  colr,
    output logic        beep
);

    game_ctrl_t ctrl;
    target_t    target;
    logic       count_over;

    game_fsm u_fsm (
        .clk        (clk),
        .sw         (sw),
        .power      (power),
        .launch     (launch),
        .confirm    (confirm),
        .guess      (guess),
        .target     (target),
        .count_over (count_over),
        .ctrl       (ctrl),
        .led        (led)
    );

    lfsr_random u_random (
        .clk     (clk),
        .sw      (sw),
        .capture (ctrl.capture),
        .target  (target)
    );

    countdown_matrix u_matrix (
        .clk         (clk),
        .sw          (sw),
        .count_start (ctrl.count_start),
        .mode        (ctrl.matrix_mode),
        .count_over  (count_over),
        .row         (row),
        .colg        (colg),
        .colr        (colr)
    );

    beeper u_beeper (
        .clk        (clk),
        .sw         (sw),
        .beep_start (ctrl.beep_start),
        .beep       (beep)
    );

    level_display u_display (
        .clk   (clk),
        .sw    (sw),
        .mode  (ctrl.matrix_mode),
        .level (ctrl.level),
        .seg   (seg),
        .dig   (dig)
    );

endmodule

`default_nettype wire

//--- tests/tb_memory_game.sv
`timescale 1ns/100ps
`default_nettype none

module tb_memory_game
    import game_pkg::*;
    import disp_pkg::*;
;

    localparam int RESET_CYCLES = 16;
    // ten level attempts of about 140 cycles plus waits, with a wide margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int COUNTDOWN_LIMIT = 4 * COUNT_STEPS * COUNT_STEP_CYCLES;
    localparam int DIGIT_LIMIT = 4 * 8 * SCAN_CYCLES;

    logic        clk;
    logic        sw;
    logic        power;
    logic        launch;
    logic        confirm;
    target_t     guess;
    logic [15:0] led;
    logic [7:0]  seg;
    logic [7:0]  dig;
    logic [7:0]  row;
    logic [7:0]  colg;
    logic [7:0]  colr;
    logic        beep;

    int          value_errors;
    int          event_errors;
    int          beep_rises;
    int          cycle_count;
    int          seed;
    logic        beep_q;
    logic [15:0] recorded;
    level_t      lvl;
    level_t      next_lvl;
    target_t     wrong;

    memory_game_top dut_i (
        .clk     (clk),
        .sw      (sw),
        .power   (power),
        .launch  (launch),
        .confirm (confirm),
        .guess   (guess),
        .led     (led),
        .seg     (seg),
        .dig     (dig),
        .row     (row),
        .colg    (colg),
        .colr    (colr),
        .beep    (beep)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // expected led mask for a level
    function automatic logic [15:0] mask_ref(level_t l);
        case (l)
            2'd1: return 16'h001f;
            2'd2: return 16'h003f;
            2'd3: return 16'h007f;
            default: return 16'h0000;
        endcase
    endfunction

    // segments {dp, g, f, e, d, c, b, a} of a level digit
    function automatic seg_pattern_t seg_ref(level_t l);
        case (l)
            2'd0: return 8'b0011_1111;
            2'd1: return 8'b0000_0110;
            2'd2: return 8'b0101_1011;
            2'd3: return 8'b0100_1111;
            default: return 8'h00;
        endcase
    endfunction

    task automatic check_led(input logic [15:0] act, input logic [15:0] exp, input string name);
        if (act !== exp)
        begin
            $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_seg(input seg_pattern_t act, input seg_pattern_t exp, input string name);
        if (act !== exp)
        begin
            $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_byte(input logic [7:0] act, input logic [7:0] exp, input string name);
        if (act !== exp)
        begin
            $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_bit(input logic act, input logic exp, input string name);
        if (act !== exp)
        begin
            $display("ERR t=%0t %s expected %b got %b", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic pulse_launch();
        @(posedge clk);
        launch <= 1'b1;
        @(posedge clk);
        launch <= 1'b0;
    endtask

    task automatic confirm_guess(input target_t value);
        @(posedge clk);
        guess <= value;
        @(posedge clk);
        confirm <= 1'b1;
        @(posedge clk);
        confirm <= 1'b0;
    endtask

    // green bar runs, then clears when the fsm enters guess
    task automatic wait_countdown_end();
        int  n;
        bit  running;
        bit  done;
        n = 0;
        running = 1'b0;
        done = 1'b0;
        while (!done && n < COUNTDOWN_LIMIT)
        begin
            @(negedge clk);
            if (colg != 8'd0)
                running = 1'b1;
            else if (running)
                done = 1'b1;
            n++;
        end
        if (!done)
        begin
            $display("the countdown did not end within %0d cycles", COUNTDOWN_LIMIT);
            event_errors++;
        end
    endtask

    task automatic wait_digit0(input level_t l);
        int n;
        n = 0;
        while (dig !== 8'hfe && n < DIGIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (dig !== 8'hfe)
        begin
            $display("digit 0 was never selected on the display");
            event_errors++;
        end
        else
            check_seg(seg, seg_ref(l), "seg digit 0");
    endtask

    task automatic observe_beep(input logic expect_tone);
        int start;
        start = beep_rises;
        repeat (BEEP_CYCLES + 16) @(negedge clk);
        check_bit(beep_rises != start, expect_tone, "beep toggled");
        check_bit(beep, 1'b0, "beep after tone");
    endtask

    task automatic check_idle_outputs();
        check_led(led, 16'd0, "led");
        check_bit(beep, 1'b0, "beep");
        check_byte(row, 8'd0, "row");
        check_byte(colg, 8'd0, "colg");
        check_byte(colr, 8'd0, "colr");
        check_byte(dig, 8'hff, "dig");
        check_seg(seg, 8'd0, "seg");
    endtask

    // tone edges and the unused led bits, every cycle
    always @(negedge clk)
    begin
        if (beep && !beep_q)
            beep_rises = beep_rises + 1;
        beep_q = beep;
        check_led(led & 16'hff80, 16'd0, "led[15:7]");
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES)
        begin
            $display("simulation timed out after %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial
    begin
        sw = 1'b1;
        power = 1'b0;
        launch = 1'b0;
        confirm = 1'b0;
        guess = '0;
        value_errors = 0;
        event_errors = 0;
        beep_rises = 0;
        cycle_count = 0;
        beep_q = 1'b0;
        seed = 32'h9059_707f;
        repeat (RESET_CYCLES) @(posedge clk);
        sw <= 1'b0;

        // power still off
        repeat (8)
        begin
            @(negedge clk);
            check_idle_outputs();
        end

        @(posedge clk);
        power <= 1'b1;
        wait_cycles(4);
        pulse_launch();
        wait_cycles(8);
        @(negedge clk);
        check_led(led & ~mask_ref(FIRST_LEVEL), 16'd0, "led above level width");
        recorded = led & mask_ref(FIRST_LEVEL);
        lvl = FIRST_LEVEL;
        wait_digit0(lvl);
        wait_countdown_end();
        check_led(led, 16'd0, "led in guess");

        // wrong guess replays the level
        wrong = target_t'($random(seed));
        if (((16'(wrong) ^ recorded) & mask_ref(lvl)) == 16'd0)
            wrong = wrong ^ 7'h01;
        confirm_guess(wrong);
        observe_beep(1'b0);
        check_led(led, recorded, "led replay");
        wait_countdown_end();
        check_led(led, 16'd0, "led in guess");
        wait_digit0(lvl);

        for (int i = 0; i < 3; i++)
        begin
            confirm_guess(target_t'(recorded));
            observe_beep(1'b1);
            if (lvl != LAST_LEVEL)
            begin
                next_lvl = lvl + 2'd1;
                @(negedge clk);
                check_led(led & ~mask_ref(next_lvl), 16'd0, "led above level width");
                check_led(led & mask_ref(lvl), recorded, "led low bits kept");
                recorded = led & mask_ref(next_lvl);
                lvl = next_lvl;
                wait_countdown_end();
                check_led(led, 16'd0, "led in guess");
                wait_digit0(lvl);
            end
        end

        // victory
        @(negedge clk);
        check_bit(row != 8'd0, 1'b1, "row selected");
        check_byte(colr, 8'hff, "colr in victory");
        check_byte(colg, 8'd0, "colg in victory");
        check_led(led, 16'd0, "led in victory");
        wait_digit0(LAST_LEVEL);

        // restart from victory
        pulse_launch();
        wait_cycles(8);
        @(negedge clk);
        check_led(led & ~mask_ref(FIRST_LEVEL), 16'd0, "led above level width");
        check_byte(colr, 8'd0, "colr after restart");
        wait_digit0(FIRST_LEVEL);

        // power drop during memorize
        @(posedge clk);
        power <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        @(negedge clk);
        check_led(led, 16'd0, "led after power off");
        check_byte(row, 8'd0, "row after power off");
        check_byte(colg, 8'd0, "colg after power off");
        check_byte(colr, 8'd0, "colr after power off");
        check_byte(dig, 8'hff, "dig after power off");

        $display("error count: %0d wrong values, %0d missing events", value_errors, event_errors);
        if (value_errors + event_errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
rtl/disp_pkg.sv
rtl/game_pkg.sv
rtl/lfsr_random.sv
rtl/countdown_matrix.sv
rtl/beeper.sv
rtl/level_display.sv
rtl/game_fsm.sv
rtl/memory_game_top.sv
tests/tb_memory_game.sv

//--- run.sh
#!/bin/sh
# compile and run the testbench, then scan the log for failures
verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_memory_game \
    && ./obj_dir/Vtb_memory_game > sim.log 2>&1 \
    || { echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
